// ==== Makefile ====
TOP := pcs_rx_lane_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -Mdir obj_dir

# pass only if the testbench printed its pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== hw/block_sync_rx.sv ====
// sync header counters and the invalid, test and lock fsm driving slip and lock
`timescale 1ns/1ps
module block_sync_rx (
	input  logic          clk,
	input  logic          nreset,
	input  logic          signal_ok_i, // serdes signal level
	pcs_lane_if.sync      blk,
	output logic          lock_o       // rx block lock
);

	pcs_pkg::sync_state_t       state_q;
	pcs_pkg::sync_state_t       state_next;

	logic                       sh_v;     // header valid when bits differ
	logic                       in_test;
	logic                       in_lock;
	logic                       in_invalid;

	// window / good counter
	logic [pcs_pkg::CNT_W-1:0]  cnt_q;
	logic [pcs_pkg::CNT_W-1:0]  cnt_add;
	logic [pcs_pkg::CNT_W-1:0]  cnt_next;
	logic                       cnt_inc;
	logic                       cnt_ovf;  // reached WIN_N

	// bad header counter
	logic [pcs_pkg::BAD_W-1:0]  bad_q;
	logic [pcs_pkg::BAD_W-1:0]  bad_add;
	logic [pcs_pkg::BAD_W-1:0]  bad_next;

	logic                       good_hit; // 64 good in a row
	logic                       bad_hit;  // 65 bad in window
	logic                       cnt_clr;
	logic                       slip;

	assign in_invalid = state_q == pcs_pkg::SYNC_INVALID;
	assign in_test    = state_q == pcs_pkg::SYNC_TEST;
	assign in_lock    = state_q == pcs_pkg::SYNC_LOCK;

	assign sh_v = blk.head[0] ^ blk.head[1]; // 01 or 10

	// in test only good headers count, in lock every header counts toward the window
	assign cnt_inc = sh_v | in_lock;
	assign {cnt_ovf, cnt_add} = cnt_q + cnt_inc;
	assign bad_add = bad_q + {{(pcs_pkg::BAD_W-1){1'b0}}, ~sh_v};

	assign good_hit = in_test & (cnt_add == pcs_pkg::CNT_W'(pcs_pkg::GOOD_N));
	assign bad_hit  = in_lock & (bad_add == pcs_pkg::BAD_W'(pcs_pkg::BAD_N));

	// slip on any bad header while testing, or on too many bad ones in lock
	assign slip = blk.blk_v & (in_test & ~sh_v | bad_hit);

	assign cnt_clr  = in_invalid | good_hit | slip | cnt_ovf;
	assign cnt_next = cnt_clr ? '0 : cnt_add;
	assign bad_next = cnt_clr ? '0 : bad_add;

	// header counters step once per block
	always_ff @(posedge clk) begin
		if (blk.blk_v) begin
			cnt_q <= cnt_next;
			bad_q <= bad_next;
		end
	end

	always_comb begin
		state_next = state_q;
		if (!signal_ok_i) begin
			state_next = pcs_pkg::SYNC_INVALID; // signal lost from any state
		end else begin
			case (state_q)
				pcs_pkg::SYNC_INVALID: state_next = pcs_pkg::SYNC_TEST;
				pcs_pkg::SYNC_TEST: begin
					if (good_hit) state_next = pcs_pkg::SYNC_LOCK;
				end
				pcs_pkg::SYNC_LOCK: begin
					if (bad_hit) state_next = pcs_pkg::SYNC_TEST; // lock lost so hunt again
				end
				default: state_next = pcs_pkg::SYNC_INVALID;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (nreset) begin
			state_q <= pcs_pkg::SYNC_INVALID;
		end else if (blk.blk_v) begin
			state_q <= state_next; // advances per block only
		end
	end

	assign blk.slip = slip;
	assign lock_o   = in_lock; // straight from the state flops

endmodule

// ==== hw/descrambler.sv ====
// descrambler: self-synchronizing 1 + x^39 + x^58 payload descrambler with output register
`timescale 1ns/1ps
module descrambler (
	input  logic             clk,
	input  logic             nreset,
	pcs_lane_if.descr        blk,
	output pcs_pkg::data_t   data_o,  // clear payload
	output logic             valid_o
);

	logic [pcs_pkg::SCR_W-1:0]                  hist_q; // received bits, [0] oldest
	logic [pcs_pkg::SCR_W+pcs_pkg::DATA_W-1:0]  ext;    // history then new bits
	pcs_pkg::data_t                             clear;

	assign ext = {blk.data, hist_q};

	// lsb first, each bit xors the line bits 39 and 58 before it
	always_comb begin
		for (int i = 0; i < pcs_pkg::DATA_W; i++) begin
			clear[i] = blk.data[i]
				^ ext[pcs_pkg::SCR_W + i - pcs_pkg::SCR_TAP_A]
				^ ext[pcs_pkg::SCR_W + i - pcs_pkg::SCR_TAP_B];
		end
	end

	// history and payload
	always_ff @(posedge clk) begin
		if (blk.blk_v) begin
			hist_q <= ext[pcs_pkg::SCR_W+pcs_pkg::DATA_W-1:pcs_pkg::DATA_W]; // last 58 line bits
			data_o <= clear;
		end
	end

	always_ff @(posedge clk) begin
		if (nreset) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= blk.blk_v; // one stage, follows every block
		end
	end

endmodule

// ==== hw/pcs_lane_if.sv ====
// lane interface carrying the aligned block and slip request, with aligner, sync and descr modports
`timescale 1ns/1ps
interface pcs_lane_if;

	logic            blk_v; // aligned block strobe
	pcs_pkg::head_t  head;  // sync header bits
	pcs_pkg::data_t  data;  // scrambled payload
	logic            slip;  // shift boundary by one bit

	modport aligner (
		output blk_v,
		output head,
		output data,
		input  slip
	);

	modport sync (
		input  blk_v,
		input  head,
		output slip
	);

	modport descr (
		input  blk_v,
		input  data
	);

endinterface

// ==== hw/pcs_pkg.sv ====
// shared widths, vector types, sync counter limits and sync fsm states for the pcs rx lane
package pcs_pkg;

	localparam int BLOCK_W = 66; // full block incl sync header
	localparam int HEAD_W  = 2;  // sync header
	localparam int DATA_W  = 64; // payload
	localparam int OFF_W   = 7;  // bit offset, 0..65

	localparam int GOOD_N = 64;   // good headers to lock
	localparam int WIN_N  = 1024; // header window in lock
	localparam int BAD_N  = 65;   // bad headers per window to drop lock
	localparam int CNT_W  = 10;   // window counter, wraps at WIN_N
	localparam int BAD_W  = 7;    // bad header counter

	localparam int SCR_W     = 58; // scrambler history length
	localparam int SCR_TAP_A = 39; // x^39
	localparam int SCR_TAP_B = 58; // x^58

	typedef logic [BLOCK_W-1:0] block_t;
	typedef logic [HEAD_W-1:0]  head_t;
	typedef logic [DATA_W-1:0]  data_t;

	// clause 49 style lock fsm
	typedef enum logic [1:0] {
		SYNC_INVALID, // no signal, waiting for signal_ok
		SYNC_TEST,    // hunting for a stable header boundary
		SYNC_LOCK     // block lock held
	} sync_state_t;

endpackage

// ==== hw/pcs_rx_lane.sv ====
// pcs_rx_lane: rx lane top joining aligner, block sync and descrambler over the lane interface
`timescale 1ns/1ps
module pcs_rx_lane (
	input  logic             clk,
	input  logic             nreset,
	input  logic             valid_i,     // raw word strobe
	input  logic             signal_ok_i, // serdes signal level
	input  pcs_pkg::block_t  raw_i,       // raw gearbox word
	output pcs_pkg::data_t   data_o,      // descrambled payload
	output logic             valid_o,     // two cycles after valid_i
	output logic             lock_o       // block lock
);

	pcs_lane_if lane ();

	// boundary search, driven by slip
	rx_aligner u_aligner (
		.clk     (clk),
		.nreset  (nreset),
		.valid_i (valid_i),
		.raw_i   (raw_i),
		.blk     (lane.aligner)
	);

	// header watch and lock fsm
	block_sync_rx u_sync (
		.clk         (clk),
		.nreset      (nreset),
		.signal_ok_i (signal_ok_i),
		.blk         (lane.sync),
		.lock_o      (lock_o)
	);

	// payload recovery, blocks in the slip cycle still go through
	descrambler u_descr (
		.clk     (clk),
		.nreset  (nreset),
		.blk     (lane.descr),
		.data_o  (data_o),
		.valid_o (valid_o)
	);

endmodule

// ==== hw/rx_aligner.sv ====
// rx_aligner: bit boundary aligner extracting 66-bit blocks at a slip controlled offset
`timescale 1ns/1ps
module rx_aligner (
	input  logic              clk,
	input  logic              nreset,
	input  logic              valid_i, // raw word present
	input  pcs_pkg::block_t   raw_i,   // raw gearbox word, bit 0 first on the wire
	pcs_lane_if.aligner       blk
);

	pcs_pkg::block_t                  prev_q; // last raw word
	logic [2*pcs_pkg::BLOCK_W-1:0]    cat;    // prev then current, in stream order
	logic [pcs_pkg::OFF_W-1:0]        off_q;  // current bit offset
	logic [pcs_pkg::OFF_W-1:0]        off_next;
	logic                             off_wrap;
	pcs_pkg::block_t                  win;    // extracted window
	pcs_pkg::block_t                  blk_q;  // registered aligned block
	logic                             blk_v_q;

	// older word sits in the low half, so offset 0 gives back the previous word
	assign cat = {raw_i, prev_q};

	// offset steps by one per slip, wraps after the last boundary
	assign off_wrap = off_q == pcs_pkg::OFF_W'(pcs_pkg::BLOCK_W - 1);

	always_comb begin
		off_next = off_q;
		if (blk.slip) begin
			off_next = off_wrap ? '0 : off_q + 1'b1; // slip lands on next extraction
		end
	end

	assign win = cat[off_next +: pcs_pkg::BLOCK_W]; // barrel select

	// control state
	always_ff @(posedge clk) begin
		if (nreset) begin
			off_q   <= '0;
			blk_v_q <= 1'b0;
		end else begin
			off_q   <= off_next; // slip only comes with blk_v
			blk_v_q <= valid_i;  // one stage
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if (valid_i) begin
			prev_q <= raw_i;
			blk_q  <= win;
		end
	end

	// header is the first two bits on the wire
	assign blk.blk_v = blk_v_q;
	assign blk.head  = blk_q[pcs_pkg::HEAD_W-1:0];
	assign blk.data  = blk_q[pcs_pkg::BLOCK_W-1:pcs_pkg::HEAD_W];

endmodule

// ==== sim/pcs_rx_lane_chk.sv ====
// pcs_rx_lane_chk: bound assertions on the block sync fsm, slip strobe and lane latency
`timescale 1ns/1ps
module pcs_rx_lane_chk (
	input logic                  clk,
	input logic                  nreset,
	input logic                  valid_i,
	input logic                  valid_o,
	input logic                  signal_ok_i,
	input logic                  lock_o,
	input logic                  blk_v,  // aligned block on the lane
	input logic                  slip,
	input pcs_pkg::sync_state_t  state   // sync fsm state
);

	a_state_legal: assert property (@(posedge clk) disable iff (nreset)
		state inside {pcs_pkg::SYNC_INVALID, pcs_pkg::SYNC_TEST, pcs_pkg::SYNC_LOCK})
		else $error("sync fsm in an illegal state");

	a_slip_blk: assert property (@(posedge clk) disable iff (nreset) slip |-> blk_v)
		else $error("slip without an aligned block");

	// fixed two stage lane
	a_latency: assert property (@(posedge clk) disable iff (nreset) valid_i |-> ##2 valid_o)
		else $error("valid_o missing two cycles after valid_i");

	a_sig_loss: assert property (@(posedge clk) disable iff (nreset)
		(blk_v && !signal_ok_i) |=> !lock_o)
		else $error("lock_o held after signal loss");

endmodule

bind pcs_rx_lane pcs_rx_lane_chk chk (
	.clk         (clk),
	.nreset      (nreset),
	.valid_i     (valid_i),
	.valid_o     (valid_o),
	.signal_ok_i (signal_ok_i),
	.lock_o      (lock_o),
	.blk_v       (lane.blk_v),
	.slip        (lane.slip),
	.state       (u_sync.state_q)
);

// ==== sim/pcs_rx_lane_tb.sv ====
// pcs_rx_lane_tb: clock, reset, scrambler model, bit stream generator, compare process, scenarios
`timescale 1ns/1ps
module pcs_rx_lane_tb;

	logic                       clk;
	logic                       nreset;
	logic                       valid_i;
	logic                       signal_ok_i;
	pcs_pkg::block_t            raw_i;
	pcs_pkg::data_t             data_o;
	logic                       valid_o;
	logic                       lock_o;

	bit                         stream_q[$];    // line bits, front goes out first
	pcs_pkg::data_t             pay_q[$];       // clear payloads of generated blocks
	pcs_pkg::data_t             exp_q[$];       // one entry per raw word sent
	logic [pcs_pkg::SCR_W-1:0]  scr_hist;       // last scrambled line bits
	int                         bad_left = 0;   // invalid headers still to insert
	int                         words_sent = 0;
	int                         lock_run = 0;   // output blocks seen with lock high
	int                         cmp_cnt = 0;

	pcs_rx_lane dut (
		.clk         (clk),
		.nreset      (nreset),
		.valid_i     (valid_i),
		.signal_ok_i (signal_ok_i),
		.raw_i       (raw_i),
		.data_o      (data_o),
		.valid_o     (valid_o),
		.lock_o      (lock_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%0t: %s", $time, why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input pcs_pkg::data_t got, input pcs_pkg::data_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// 1 + x^39 + x^58, each line bit feeds back from the line bits before it
	function automatic pcs_pkg::data_t scramble(input pcs_pkg::data_t d,
			input logic [pcs_pkg::SCR_W-1:0] hist);
		logic [pcs_pkg::SCR_W+pcs_pkg::DATA_W-1:0] line;
		line = {{pcs_pkg::DATA_W{1'b0}}, hist};
		for (int i = 0; i < pcs_pkg::DATA_W; i++) begin
			line[pcs_pkg::SCR_W+i] = d[i] ^ line[pcs_pkg::SCR_W+i-pcs_pkg::SCR_TAP_A]
				^ line[pcs_pkg::SCR_W+i-pcs_pkg::SCR_TAP_B];
		end
		return line[pcs_pkg::SCR_W +: pcs_pkg::DATA_W];
	endfunction

	task automatic gen_block();
		pcs_pkg::data_t pay;
		pcs_pkg::data_t scr;
		pcs_pkg::head_t h;
		pcs_pkg::block_t b;
		pay = {$urandom, $urandom};
		if (bad_left > 0) begin
			h = $urandom_range(0, 1) ? 2'b11 : 2'b00; // invalid header
			bad_left--;
		end else begin
			h = ($urandom_range(0, 3) == 0) ? 2'b10 : 2'b01; // mostly data blocks
		end
		scr = scramble(pay, scr_hist);
		scr_hist = scr[pcs_pkg::DATA_W-1:pcs_pkg::DATA_W-pcs_pkg::SCR_W];
		b = {scr, h}; // header goes out first
		for (int i = 0; i < pcs_pkg::BLOCK_W; i++) begin
			stream_q.push_back(b[i]);
		end
		pay_q.push_back(pay);
	endtask

	// raw word j carries the tail of block j-1
	task automatic send_word(input bit gaps);
		pcs_pkg::block_t w;
		int idle;
		idle = 0;
		if (gaps && $urandom_range(0, 3) == 0) begin
			idle = $urandom_range(1, 3);
		end
		repeat (idle) begin
			@(negedge clk);
			valid_i = 1'b0;
		end
		if (stream_q.size() < pcs_pkg::BLOCK_W) begin
			gen_block();
		end
		for (int i = 0; i < pcs_pkg::BLOCK_W; i++) begin
			w[i] = stream_q.pop_front();
		end
		@(negedge clk);
		valid_i = 1'b1;
		raw_i   = w;
		if (words_sent == 0) begin
			exp_q.push_back('0); // first block has no previous word
		end else begin
			exp_q.push_back(pay_q.pop_front());
		end
		words_sent++;
	endtask

	task automatic wait_lock(input bit gaps);
		int n;
		n = 0;
		while (!lock_o) begin
			if (n >= pcs_pkg::BLOCK_W * (pcs_pkg::BLOCK_W - 1)) begin
				abort_run("lock_o did not rise within the acquisition timeout");
			end
			send_word(gaps);
			n++;
		end
	endtask

	task automatic wait_unlock();
		int n;
		n = 0;
		while (lock_o) begin
			if (n >= 16) begin
				abort_run("lock_o stayed high after the 65th invalid header");
			end
			send_word(1'b0);
			n++;
		end
	endtask

	always @(negedge clk) begin : compare_out
		pcs_pkg::data_t exp;
		if (!nreset && valid_o) begin
			lock_run = lock_o ? lock_run + 1 : 0;
			if (exp_q.size() == 0) begin
				abort_run("output block arrived with no expected payload");
			end else begin
				exp = exp_q.pop_front();
				if (lock_run >= 2) begin // lock held over two blocks
					check("data_o", data_o, exp);
					cmp_cnt++;
				end
			end
		end
	end

	initial begin
		int start_off;
		int n;
		void'($urandom(59));
		nreset      = 1'b1;
		valid_i     = 1'b0;
		signal_ok_i = 1'b1;
		raw_i       = '0;
		scr_hist    = pcs_pkg::SCR_W'({$urandom, $urandom});
		start_off   = $urandom_range(1, pcs_pkg::BLOCK_W - 1);
		repeat (start_off) stream_q.push_back(1'($urandom)); // junk ahead of block 0

		repeat (8) begin
			@(negedge clk);
			check("valid_o", pcs_pkg::data_t'(valid_o), '0);
			check("lock_o", pcs_pkg::data_t'(lock_o), '0);
		end
		nreset = 1'b0;
		repeat (2) begin
			@(negedge clk);
			check("valid_o", pcs_pkg::data_t'(valid_o), '0);
			check("lock_o", pcs_pkg::data_t'(lock_o), '0);
		end

		wait_lock(1'b0);                   // hunt from the random offset
		repeat (300) send_word(1'b1);      // payload with valid gaps

		bad_left = 64;                     // stays under the window limit
		n = 0;
		while (bad_left > 0) begin
			if (n >= 200) begin
				abort_run("invalid header burst was never sent");
			end
			send_word(1'b0);
			n++;
		end
		repeat (6) send_word(1'b0);        // let the burst reach the fsm
		check("lock_o", pcs_pkg::data_t'(lock_o), pcs_pkg::data_t'(1'b1));
		bad_left = 1;                      // 65th in the same window
		wait_unlock();
		wait_lock(1'b0);                   // full slip cycle back to the boundary
		repeat (40) send_word(1'b1);

		repeat (2) send_word(1'b0);
		signal_ok_i = 1'b0;                // low across one block
		send_word(1'b0);
		signal_ok_i = 1'b1;
		check("lock_o", pcs_pkg::data_t'(lock_o), '0);
		wait_lock(1'b0);
		repeat (60) send_word(1'b1);

		@(negedge clk);
		valid_i = 1'b0;
		repeat (3) @(negedge clk);         // drain the two stage lane
		if (cmp_cnt < 250) begin
			abort_run("too few payload blocks were compared");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

// ==== vlog.f ====
hw/pcs_pkg.sv
hw/pcs_lane_if.sv
hw/rx_aligner.sv
hw/block_sync_rx.sv
hw/descrambler.sv
hw/pcs_rx_lane.sv
sim/pcs_rx_lane_chk.sv
sim/pcs_rx_lane_tb.sv
